//--- project.f
logic/stream_pkg.sv
logic/uart_pkg.sv
logic/uart_byte_rx.sv
logic/sample_loader.sv
logic/write_source_select.sv
logic/word_stacker.sv
logic/chunk_fifo.sv
logic/dram_writer.sv
verification/dram_writer_chk.sv
verification/dram_writer_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= dram_writer_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG) || \
	   ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/dram_writer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dram_writer_tb;

    localparam int num_tests     = 3;
    localparam int num_cols      = 12;
    localparam int col_count     = 0;  // four instrument counts.
    localparam int col_video     = 4;
    localparam int col_pixels    = 5;
    localparam int col_busy      = 6;  // percent of cycles with out_ready low.
    localparam int col_offset    = 7;  // five expected offsets, in chunks.
    localparam int settle_cycles = 400;

    localparam int test_table [num_tests][num_cols] = '{
        '{8, 3, 0, 17,   0,  0,  0,   0, 1, 2, 2, 5},
        '{1, 0, 9, 2,    1, 20,  0,   0, 1, 1, 3, 4},
        '{5, 16, 7, 0,   1, 13, 50,   0, 1, 3, 4, 4}
    };

    logic                    clk_pixel   = 1'b0;
    logic                    rst_pixel   = 1'b1;
    logic                    uart_din    = 1'b1;
    logic                    video_ready = 1'b0;
    logic                    pixel_valid = 1'b0;
    stream_pkg::word_t       pixel_data  = '0;
    logic                    pixel_last  = 1'b0;
    logic                    out_ready   = 1'b1;
    stream_pkg::chunk_addr_t addr_offsets [stream_pkg::instrument_count:0];
    logic                    addr_offsets_valid;
    logic                    video_active;
    logic                    overflow;
    logic                    out_valid;
    stream_pkg::chunk_t      out_data;
    logic                    out_last;

    stream_pkg::chunk_t exp_data_q [$];
    logic               exp_last_q [$];
    stream_pkg::chunk_t pack_data   = '0;
    int                 pack_idx    = 0;
    int                 busy_pct    = 0;
    int                 errors      = 0;
    int                 chunks_seen = 0;
    int                 pass_count  = 0;
    int                 fail_count  = 0;

    always #2 clk_pixel = ~clk_pixel;

    dram_writer dram_writer_inst (
        .clk_pixel          (clk_pixel),
        .rst_pixel          (rst_pixel),
        .uart_din           (uart_din),
        .video_ready        (video_ready),
        .pixel_valid        (pixel_valid),
        .pixel_data         (pixel_data),
        .pixel_last         (pixel_last),
        .out_ready          (out_ready),
        .addr_offsets       (addr_offsets),
        .addr_offsets_valid (addr_offsets_valid),
        .video_active       (video_active),
        .overflow           (overflow),
        .out_valid          (out_valid),
        .out_data           (out_data),
        .out_last           (out_last)
    );

    bind dram_writer dram_writer_chk dram_writer_chk_inst (
        .clk_pixel          (clk_pixel),
        .rst_pixel          (rst_pixel),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_data           (out_data),
        .out_last           (out_last),
        .overflow           (overflow),
        .addr_offsets_valid (addr_offsets_valid),
        .video_active       (video_active)
    );

    task automatic compare_value(input string what, input logic [127:0] actual,
                                 input logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERROR @ %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // compare mismatches plus failed assertions.
    function automatic int error_total();
        return errors + dram_writer_inst.dram_writer_chk_inst.failures;
    endfunction

    // word n lands in bits 16n+15:16n, zeros above the final word.
    task automatic pack_word(input stream_pkg::word_t word, input logic last);
        pack_data[pack_idx*16 +: 16] = word;
        pack_idx++;
        if (last || pack_idx == stream_pkg::words_per_chunk) begin
            exp_data_q.push_back(pack_data);
            exp_last_q.push_back(last);
            pack_data = '0;
            pack_idx  = 0;
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};  // stop, data lsb first, start.
        for (int b = 0; b < 10; b++) begin
            @(posedge clk_pixel);
            uart_din <= frame[b];
            repeat (uart_pkg::clks_per_bit - 1) @(posedge clk_pixel);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_pixel);
        rst_pixel   <= 1'b1;
        uart_din    <= 1'b1;
        video_ready <= 1'b0;
        pixel_valid <= 1'b0;
        pixel_last  <= 1'b0;
        repeat (8) @(posedge clk_pixel);
        rst_pixel <= 1'b0;
        @(posedge clk_pixel);
        compare_value("out_valid after reset", out_valid, 1'b0);
        compare_value("addr_offsets_valid after reset", addr_offsets_valid, 1'b0);
        compare_value("video_active after reset", video_active, 1'b0);
        compare_value("overflow after reset", overflow, 1'b0);
        for (int i = 0; i <= stream_pkg::instrument_count; i++) begin
            compare_value($sformatf("addr_offsets[%0d] after reset", i), addr_offsets[i], '0);
        end
    endtask

    task automatic upload_samples(input int t);
        int                count;
        stream_pkg::word_t sample;
        for (int i = 0; i < stream_pkg::instrument_count; i++) begin
            count = test_table[t][col_count + i];
            send_byte(count[7:0]);
            send_byte(count[15:8]);
            for (int s = 0; s < count; s++) begin
                sample = stream_pkg::word_t'($urandom);
                pack_word(sample, s == count - 1);
                send_byte(sample[7:0]);
                send_byte(sample[15:8]);
            end
        end
        while (!addr_offsets_valid) @(posedge clk_pixel);
        for (int i = 0; i <= stream_pkg::instrument_count; i++) begin
            compare_value($sformatf("addr_offsets[%0d]", i), addr_offsets[i],
                          128'(test_table[t][col_offset + i]));
        end
    endtask

    task automatic drain_chunks();
        while (exp_data_q.size() != 0) @(posedge clk_pixel);
        repeat (20) @(posedge clk_pixel);  // room for any extra chunk.
    endtask

    task automatic stream_pixels(input int t);
        stream_pkg::word_t pixel;
        // a full chunk with last, not routed yet.
        for (int p = 0; p < stream_pkg::words_per_chunk; p++) begin
            @(posedge clk_pixel);
            pixel_valid <= 1'b1;
            pixel_data  <= stream_pkg::word_t'($urandom);
            pixel_last  <= (p == stream_pkg::words_per_chunk - 1);
        end
        @(posedge clk_pixel);
        pixel_valid <= 1'b0;
        pixel_last  <= 1'b0;
        repeat (20) @(posedge clk_pixel);
        compare_value("video_active before video_ready", video_active, 1'b0);
        video_ready <= 1'b1;
        while (!video_active) @(posedge clk_pixel);
        for (int p = 0; p < test_table[t][col_pixels]; p++) begin
            pixel = stream_pkg::word_t'($urandom);
            pack_word(pixel, p == test_table[t][col_pixels] - 1);
            @(posedge clk_pixel);
            pixel_valid <= 1'b1;
            pixel_data  <= pixel;
            pixel_last  <= (p == test_table[t][col_pixels] - 1);
        end
        @(posedge clk_pixel);
        pixel_valid <= 1'b0;
        pixel_last  <= 1'b0;
        drain_chunks();
        compare_value("video_active", video_active, 1'b1);
    endtask

    task automatic run_test(input int t);
        int errors_before;
        int chunks_before;
        errors_before = error_total();
        chunks_before = chunks_seen;
        exp_data_q.delete();
        exp_last_q.delete();
        pack_data = '0;
        pack_idx  = 0;
        busy_pct  = test_table[t][col_busy];
        apply_reset();
        upload_samples(t);
        drain_chunks();
        if (test_table[t][col_video] != 0) begin
            stream_pixels(t);
        end
        compare_value("overflow", overflow, 1'b0);
        if (error_total() == errors_before) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d: %s, %0d chunks, %0d errors", t,
                 (error_total() == errors_before) ? "ok" : "failed",
                 chunks_seen - chunks_before, error_total() - errors_before);
    endtask

    function automatic longint watchdog_ns();
        longint cycles;
        int     bytes;
        cycles = 0;
        for (int t = 0; t < num_tests; t++) begin
            bytes = 0;
            for (int i = 0; i < stream_pkg::instrument_count; i++) begin
                bytes += 2 + 2 * test_table[t][col_count + i];
            end
            cycles += bytes * 10 * uart_pkg::clks_per_bit;
            cycles += test_table[t][col_pixels] + settle_cycles;
        end
        return cycles * 4 * 2;  // 4 ns period, twice the estimate.
    endfunction

    // ========================================================================
    // consumer side
    // ========================================================================

    always @(posedge clk_pixel) begin
        out_ready <= (int'($urandom_range(99)) >= busy_pct);
    end

    always @(posedge clk_pixel) begin
        if (!rst_pixel && out_valid && out_ready) begin
            chunks_seen++;
            if (exp_data_q.size() == 0) begin
                $display("chunk received at %0t ns when no chunk was expected", $time);
                errors++;
            end else begin
                compare_value("out_data", out_data, exp_data_q.pop_front());
                compare_value("out_last", out_last, exp_last_q.pop_front());
            end
        end
    end

    initial begin
        #(watchdog_ns());
        $display("watchdog expired, the run timed out before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(32'hfac4_3e5c));
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_total() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dram_writer_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dram_writer_chk (
    input  wire                     clk_pixel,
    input  wire                     rst_pixel,
    input  wire                     out_valid,
    input  wire                     out_ready,
    input  wire stream_pkg::chunk_t out_data,
    input  wire                     out_last,
    input  wire                     overflow,
    input  wire                     addr_offsets_valid,
    input  wire                     video_active
);

    int failures = 0;  // failed assertion count.

    // a stalled chunk holds until the consumer takes it.
    property hold_until_ready;
        @(posedge clk_pixel) disable iff (rst_pixel)
            out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last);
    endproperty

    property no_overflow;
        @(posedge clk_pixel) disable iff (rst_pixel) !overflow;
    endproperty

    property table_valid_sticky;
        @(posedge clk_pixel) disable iff (rst_pixel) addr_offsets_valid |=> addr_offsets_valid;
    endproperty

    property video_sticky;
        @(posedge clk_pixel) disable iff (rst_pixel) video_active |=> video_active;
    endproperty

    hold_a: assert property (hold_until_ready)
        else begin
            $error("out_valid dropped or chunk changed before out_ready");
            failures++;
        end
    overflow_a: assert property (no_overflow)
        else begin
            $error("chunk dropped on a full FIFO");
            failures++;
        end
    table_a: assert property (table_valid_sticky)
        else begin
            $error("addr_offsets_valid fell without reset");
            failures++;
        end
    video_a: assert property (video_sticky)
        else begin
            $error("video_active fell without reset");
            failures++;
        end

endmodule

`default_nettype wire

//--- logic/dram_writer.sv
`timescale 1ns/1ps
`default_nettype none

module dram_writer (
    input  wire                     clk_pixel,
    input  wire                     rst_pixel,
    input  wire                     uart_din,
    input  wire                     video_ready,
    input  wire                     pixel_valid,
    input  wire stream_pkg::word_t  pixel_data,
    input  wire                     pixel_last,
    input  wire                     out_ready,
    output stream_pkg::chunk_addr_t addr_offsets [stream_pkg::instrument_count:0],
    output logic                    addr_offsets_valid,
    output logic                    video_active,
    output logic                    overflow,
    output logic                    out_valid,
    output stream_pkg::chunk_t      out_data,
    output logic                    out_last
);

    uart_pkg::uart_byte_t rx_byte;
    logic                 rx_valid;
    logic                 sample_valid;
    stream_pkg::word_t    sample_data;
    logic                 sample_last;
    logic                 stacker_valid;
    stream_pkg::word_t    stacker_data;
    logic                 stacker_last;
    logic                 stacker_restart;
    logic                 chunk_valid;
    stream_pkg::chunk_t   chunk_data;
    logic                 chunk_last;
    logic                 fifo_full;

    // ========================================================================
    // sample upload
    // ========================================================================

    uart_byte_rx uart_byte_rx_inst (
        .clk_pixel (clk_pixel),
        .rst_pixel (rst_pixel),
        .uart_din  (uart_din),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    sample_loader sample_loader_inst (
        .clk_pixel    (clk_pixel),
        .rst_pixel    (rst_pixel),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_last  (sample_last),
        .addr_offsets (addr_offsets),
        .load_done    (addr_offsets_valid)  // table complete.
    );

    // ========================================================================
    // chunk path
    // ========================================================================

    write_source_select write_source_select_inst (
        .clk_pixel       (clk_pixel),
        .rst_pixel       (rst_pixel),
        .load_done       (addr_offsets_valid),
        .video_ready     (video_ready),
        .pixel_valid     (pixel_valid),
        .pixel_data      (pixel_data),
        .pixel_last      (pixel_last),
        .sample_valid    (sample_valid),
        .sample_data     (sample_data),
        .sample_last     (sample_last),
        .stacker_valid   (stacker_valid),
        .stacker_data    (stacker_data),
        .stacker_last    (stacker_last),
        .stacker_restart (stacker_restart),
        .video_en        (video_active)
    );

    word_stacker word_stacker_inst (
        .clk_pixel   (clk_pixel),
        .rst_pixel   (rst_pixel),
        .restart     (stacker_restart),
        .in_valid    (stacker_valid),
        .in_data     (stacker_data),
        .in_last     (stacker_last),
        .fifo_full   (fifo_full),
        .chunk_valid (chunk_valid),
        .chunk_data  (chunk_data),
        .chunk_last  (chunk_last),
        .overflow    (overflow)
    );

    chunk_fifo chunk_fifo_inst (
        .clk_pixel (clk_pixel),
        .rst_pixel (rst_pixel),
        .push      (chunk_valid),
        .push_data (chunk_data),
        .push_last (chunk_last),
        .full      (fifo_full),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- logic/chunk_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_fifo (
    input  wire                     clk_pixel,
    input  wire                     rst_pixel,
    input  wire                     push,
    input  wire stream_pkg::chunk_t push_data,
    input  wire                     push_last,
    output logic                    full,
    output logic                    out_valid,
    output stream_pkg::chunk_t      out_data,
    output logic                    out_last,
    input  wire                     out_ready
);

    stream_pkg::chunk_t      data_mem [stream_pkg::fifo_depth];
    logic                    last_mem [stream_pkg::fifo_depth];
    stream_pkg::fifo_ptr_t   wr_ptr;
    stream_pkg::fifo_ptr_t   rd_ptr;
    stream_pkg::fifo_count_t count;
    logic                    do_push;
    logic                    do_pop;

    assign full      = (count == stream_pkg::fifo_full_count);
    assign out_valid = (count != '0);
    assign out_data  = data_mem[rd_ptr];  // fall-through head.
    assign out_last  = last_mem[rd_ptr];
    assign do_push   = push & ~full;
    assign do_pop    = out_valid & out_ready;

    always_ff @(posedge clk_pixel) begin
        if (do_push) begin
            data_mem[wr_ptr] <= push_data;
            last_mem[wr_ptr] <= push_last;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/word_stacker.sv
`timescale 1ns/1ps
`default_nettype none

module word_stacker (
    input  wire                    clk_pixel,
    input  wire                    rst_pixel,
    input  wire                    restart,
    input  wire                    in_valid,
    input  wire stream_pkg::word_t in_data,
    input  wire                    in_last,
    input  wire                    fifo_full,
    output logic                   chunk_valid,
    output stream_pkg::chunk_t     chunk_data,
    output logic                   chunk_last,
    output logic                   overflow
);

    stream_pkg::word_idx_t word_idx;
    stream_pkg::word_idx_t base_idx;
    stream_pkg::chunk_t    shreg;
    stream_pkg::chunk_t    shifted;
    logic                  complete;

    // restart drops the partial chunk, the word on that cycle is word 0.
    assign base_idx = restart ? '0 : word_idx;
    assign shifted  = {in_data, shreg[$bits(stream_pkg::chunk_t)-1:$bits(stream_pkg::word_t)]};
    assign complete = in_valid && (in_last || base_idx == stream_pkg::last_word);

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            word_idx    <= '0;
            chunk_valid <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            chunk_valid <= complete;
            overflow    <= overflow | (chunk_valid & fifo_full);  // push lost.
            if (in_valid) begin
                word_idx <= complete ? '0 : base_idx + 1'b1;
            end else if (restart) begin
                word_idx <= '0;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (in_valid) begin
            shreg <= shifted;
        end
        if (complete) begin
            // align word 0 to the bottom, zeros shift in above the last word.
            chunk_data <= shifted >> {stream_pkg::last_word - base_idx, 4'b0000};
            chunk_last <= in_last;
        end
    end

endmodule

`default_nettype wire

//--- logic/write_source_select.sv
`timescale 1ns/1ps
`default_nettype none

module write_source_select (
    input  wire                    clk_pixel,
    input  wire                    rst_pixel,
    input  wire                    load_done,
    input  wire                    video_ready,
    input  wire                    pixel_valid,
    input  wire stream_pkg::word_t pixel_data,
    input  wire                    pixel_last,
    input  wire                    sample_valid,
    input  wire stream_pkg::word_t sample_data,
    input  wire                    sample_last,
    output logic                   stacker_valid,
    output stream_pkg::word_t      stacker_data,
    output logic                   stacker_last,
    output logic                   stacker_restart,
    output logic                   video_en
);

    logic enable_req;

    assign enable_req = load_done & video_ready;

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            video_en        <= 1'b0;
            stacker_restart <= 1'b0;
        end else begin
            video_en        <= video_en | enable_req;  // sticky.
            stacker_restart <= enable_req & ~video_en;  // first cycle only.
        end
    end

    always_comb begin
        if (video_en) begin
            stacker_valid = pixel_valid;
            stacker_data  = pixel_data;
            stacker_last  = pixel_last;
        end else begin
            stacker_valid = sample_valid;
            stacker_data  = sample_data;
            stacker_last  = sample_last;
        end
    end

endmodule

`default_nettype wire

//--- logic/sample_loader.sv
`timescale 1ns/1ps
`default_nettype none

module sample_loader (
    input  wire                     clk_pixel,
    input  wire                     rst_pixel,
    input  wire uart_pkg::uart_byte_t rx_byte,
    input  wire                     rx_valid,
    output logic                    sample_valid,
    output stream_pkg::word_t       sample_data,
    output logic                    sample_last,
    output stream_pkg::chunk_addr_t addr_offsets [stream_pkg::instrument_count:0],
    output logic                    load_done
);

    stream_pkg::loader_state_t   state;
    stream_pkg::instrument_idx_t inst_idx;
    stream_pkg::sample_count_t   remaining;
    stream_pkg::word_idx_t       word_idx;
    stream_pkg::chunk_addr_t     chunk_cnt;
    stream_pkg::chunk_addr_t     chunk_next;
    uart_pkg::uart_byte_t        byte_lo;
    logic                        inst_end;

    // ========================================================================
    // chunk accounting
    // ========================================================================

    always_comb begin
        inst_end   = 1'b0;
        chunk_next = chunk_cnt;
        if (rx_valid && state == stream_pkg::len_hi) begin
            inst_end = ({rx_byte, byte_lo} == '0);  // empty instrument.
        end
        if (rx_valid && state == stream_pkg::data_hi) begin
            inst_end = (remaining == stream_pkg::sample_count_t'(1));
            // padded tail chunk counts as a whole chunk.
            if (inst_end || word_idx == stream_pkg::last_word) begin
                chunk_next = chunk_cnt + 1'b1;
            end
        end
    end

    // ========================================================================
    // byte stream parser
    // ========================================================================

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            state        <= stream_pkg::idle_len_lo;
            inst_idx     <= '0;
            word_idx     <= '0;
            chunk_cnt    <= '0;
            sample_valid <= 1'b0;
            load_done    <= 1'b0;
            for (int i = 0; i <= stream_pkg::instrument_count; i++) begin
                addr_offsets[i] <= '0;
            end
        end else begin
            sample_valid <= 1'b0;
            chunk_cnt    <= chunk_next;
            if (rx_valid) begin
                case (state)
                    stream_pkg::idle_len_lo: begin
                        byte_lo <= rx_byte;
                        state   <= stream_pkg::len_hi;
                    end
                    stream_pkg::len_hi: begin
                        remaining              <= {rx_byte, byte_lo};
                        addr_offsets[inst_idx] <= chunk_cnt;  // start of this instrument.
                        word_idx               <= '0;
                        state                  <= stream_pkg::data_lo;
                    end
                    stream_pkg::data_lo: begin
                        byte_lo <= rx_byte;
                        state   <= stream_pkg::data_hi;
                    end
                    stream_pkg::data_hi: begin
                        sample_valid <= 1'b1;
                        sample_data  <= {rx_byte, byte_lo};
                        sample_last  <= inst_end;
                        remaining    <= remaining - 1'b1;
                        word_idx     <= word_idx + 1'b1;
                        state        <= stream_pkg::data_lo;
                    end
                    default: ;  // done ignores further bytes.
                endcase
                if (inst_end) begin
                    if (inst_idx == stream_pkg::last_instrument) begin
                        addr_offsets[stream_pkg::instrument_count] <= chunk_next;  // total.
                        load_done <= 1'b1;
                        state     <= stream_pkg::done;
                    end else begin
                        inst_idx <= inst_idx + 1'b1;
                        state    <= stream_pkg::idle_len_lo;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx (
    input  wire                  clk_pixel,
    input  wire                  rst_pixel,
    input  wire                  uart_din,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                 rx_valid
);

    logic [1:0]           din_sync;
    uart_pkg::rx_state_t  state;
    uart_pkg::tick_t      tick_cnt;
    logic [2:0]           bit_idx;
    uart_pkg::uart_byte_t shift;

    assign rx_byte = shift;

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            din_sync <= 2'b11;  // line idles high.
            state    <= uart_pkg::idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            din_sync <= {din_sync[0], uart_din};
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                uart_pkg::idle: begin
                    tick_cnt <= '0;
                    if (!din_sync[1]) begin
                        state <= uart_pkg::start;  // falling start edge.
                    end
                end
                uart_pkg::start: begin
                    if (tick_cnt == uart_pkg::mid_tick) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= din_sync[1] ? uart_pkg::idle : uart_pkg::data;
                    end
                end
                uart_pkg::data: begin
                    if (tick_cnt == uart_pkg::last_tick) begin
                        tick_cnt <= '0;
                        shift    <= {din_sync[1], shift[7:1]};  // lsb first.
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::stop;
                        end
                    end
                end
                uart_pkg::stop: begin
                    if (tick_cnt == uart_pkg::last_tick) begin
                        rx_valid <= din_sync[1];  // drop framing errors.
                        state    <= uart_pkg::idle;
                    end
                end
                default: state <= uart_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam int clks_per_bit = 8;  // short bit time for simulation.

    typedef logic [7:0]                      uart_byte_t;
    typedef logic [$clog2(clks_per_bit)-1:0] tick_t;

    localparam tick_t mid_tick  = tick_t'(clks_per_bit / 2 - 1);
    localparam tick_t last_tick = tick_t'(clks_per_bit - 1);

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } rx_state_t;

endpackage

`default_nettype wire

//--- logic/stream_pkg.sv
`default_nettype none

package stream_pkg;

    localparam int instrument_count = 4;
    localparam int words_per_chunk  = 8;
    localparam int fifo_depth       = 16;

    typedef logic [15:0]                        word_t;
    typedef logic [words_per_chunk*16-1:0]      chunk_t;  // word 0 in bits 15:0.
    typedef logic [23:0]                        chunk_addr_t;
    typedef logic [15:0]                        sample_count_t;
    typedef logic [$clog2(words_per_chunk)-1:0] word_idx_t;
    typedef logic [$clog2(instrument_count+1)-1:0] instrument_idx_t;
    typedef logic [$clog2(fifo_depth)-1:0]      fifo_ptr_t;
    typedef logic [$clog2(fifo_depth):0]        fifo_count_t;

    localparam word_idx_t       last_word       = word_idx_t'(words_per_chunk - 1);
    localparam instrument_idx_t last_instrument = instrument_idx_t'(instrument_count - 1);
    localparam fifo_count_t     fifo_full_count = fifo_count_t'(fifo_depth);

    typedef enum logic [2:0] {
        idle_len_lo,
        len_hi,
        data_lo,
        data_hi,
        done
    } loader_state_t;

endpackage

`default_nettype wire
